// ==== compile.f ====
src/pool_pkg.sv
src/pool_core.sv
src/pool_mem_if.sv
src/pool_unit.sv
test/feature_mem_model.sv
test/tb_pool_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pool_unit testbench with Verilator and run it
# Exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_pool_unit \
    -o sim_pool_unit &&
./obj_dir/sim_pool_unit | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== test/tb_pool_unit.sv ====
// Testbench for pool_unit with 4 cores and a random-latency feature memory
// Phases K=1, K=5, K=17, each next K offered while groups still drain
// Scoreboard updates on the falling edge, concurrent assertions check on the rise
`default_nettype none

module tb_pool_unit;

    localparam int POOL_CORE = 4;
    localparam int TAG_DEPTH = 8;
    localparam int ADDR_SPAN = 1 << pool_pkg::IDX_WIDTH;
    localparam int K1 = 1;
    localparam int G1 = 6;
    localparam int K2 = 5;
    localparam int G2 = 4;
    localparam int K3 = 17;
    localparam int G3 = 2;
    localparam int WATCHDOG_TIME = (G1 * K1 + G2 * K2 + G3 * K3) * 40 + 2000;

    logic                           clk;
    logic                           rst;
    logic                           cfg_vld;
    pool_pkg::kcnt_t                cfg_k;
    logic                           cfg_rdy;
    logic                           idx_vld;
    pool_pkg::idx_t [POOL_CORE-1:0] idx_word;
    logic                           idx_rdy;
    logic                           mem_addr_vld;
    pool_pkg::idx_t                 mem_addr;
    logic                           mem_addr_rdy;
    logic                           mem_fm_vld;
    pool_pkg::fm_t                  mem_fm;
    logic                           mem_fm_rdy;
    logic                           out_vld;
    pool_pkg::pool_out_t            out_data;
    logic                           out_rdy;

    // Scoreboard state
    pool_pkg::idx_t      idx_q [POOL_CORE][$];
    int                  pending [ADDR_SPAN];
    pool_pkg::kcnt_t     cur_k;
    pool_pkg::fm_t       exp_fm;
    pool_pkg::pool_out_t held_obs;
    pool_pkg::pool_out_t held_chk;
    bit                  exp_valid;
    bit                  addr_known;
    bit                  cfg_seen;
    bit                  work_open;
    bit                  stall_obs;
    bit                  stall_chk;
    bit                  rst_was;
    bit                  reset_pulse;
    int                  errors;
    int                  results;

    pool_unit #(
        .POOL_CORE (POOL_CORE),
        .TAG_DEPTH (TAG_DEPTH)
    ) pool_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .cfg_vld      (cfg_vld),
        .cfg_k        (cfg_k),
        .cfg_rdy      (cfg_rdy),
        .idx_vld      (idx_vld),
        .idx_word     (idx_word),
        .idx_rdy      (idx_rdy),
        .mem_addr_vld (mem_addr_vld),
        .mem_addr     (mem_addr),
        .mem_addr_rdy (mem_addr_rdy),
        .mem_fm_vld   (mem_fm_vld),
        .mem_fm       (mem_fm),
        .mem_fm_rdy   (mem_fm_rdy),
        .out_vld      (out_vld),
        .out_data     (out_data),
        .out_rdy      (out_rdy)
    );

    feature_mem_model feature_mem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .addr_vld (mem_addr_vld),
        .addr     (mem_addr),
        .addr_rdy (mem_addr_rdy),
        .fm_vld   (mem_fm_vld),
        .fm       (mem_fm),
        .fm_rdy   (mem_fm_rdy)
    );

    always #4 clk = ~clk;

    // ========================================
    // Reference rules
    // ========================================
    // Same content the memory holds for address a
    function automatic pool_pkg::fm_t feature_at(input pool_pkg::idx_t a);
        pool_pkg::fm_t f;
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
            f[ch] = pool_pkg::act_t'(int'(a) * (2 * ch + 1) + (int'(a) >> 5) * 13 + ch * 41);
        end
        return f;
    endfunction

    function automatic pool_pkg::fm_t fm_max(input pool_pkg::fm_t a, input pool_pkg::fm_t b);
        pool_pkg::fm_t m;
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
            m[ch] = (a[ch] > b[ch]) ? a[ch] : b[ch];
        end
        return m;
    endfunction

    function automatic bit queues_empty();
        for (int c = 0; c < POOL_CORE; c++) begin
            if (idx_q[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ========================================
    // Monitor, falling edge
    // ========================================
    always @(negedge clk) begin : monitor
        pool_pkg::fm_t      acc;
        pool_pkg::core_id_t c;
        reset_pulse = rst_was && !rst;
        rst_was     = rst;
        // Stall seen one cycle back, checked on this rise
        stall_chk   = stall_obs;
        held_chk    = held_obs;
        stall_obs   = out_vld && !out_rdy;
        held_obs    = out_data;
        // Work from earlier edges only
        work_open   = !queues_empty();
        if (!rst) begin
            if (cfg_vld && cfg_rdy) begin
                cur_k    = cfg_k;
                cfg_seen = 1'b1;
            end
            if (mem_addr_vld && mem_addr_rdy) begin
                addr_known = pending[mem_addr] > 0;
                if (addr_known) begin
                    pending[mem_addr]--;
                end
            end
            if (idx_vld && idx_rdy) begin
                for (int n = 0; n < POOL_CORE; n++) begin
                    idx_q[n].push_back(idx_word[n]);
                    pending[idx_word[n]]++;
                end
            end
            if (out_vld && out_rdy) begin
                c         = out_data.core;
                exp_valid = idx_q[c].size() >= int'(cur_k);
                acc       = '0;
                if (exp_valid) begin
                    for (int n = 0; n < int'(cur_k); n++) begin
                        acc = fm_max(acc, feature_at(idx_q[c].pop_front()));
                    end
                end
                exp_fm = acc;
                results++;
            end
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_reset_state: assert property (@(posedge clk)
        reset_pulse |-> cfg_rdy && !idx_rdy && !mem_addr_vld && !out_vld)
        else begin
            errors++;
            $display("Outputs not in their reset state after reset");
        end

    a_no_idx_before_cfg: assert property (@(posedge clk) disable iff (rst)
        !cfg_seen |-> !idx_rdy)
        else begin
            errors++;
            $display("Index ready raised before any configuration");
        end

    a_cfg_gating: assert property (@(posedge clk) disable iff (rst)
        work_open |-> !cfg_rdy)
        else begin
            errors++;
            $display("Configuration ready while pooling work is outstanding");
        end

    a_result_known: assert property (@(posedge clk) disable iff (rst)
        out_vld && out_rdy |-> exp_valid)
        else begin
            errors++;
            $display("Result from core %0d without a full group of indices", out_data.core);
        end

    // A wrong core field pools another core's indices and fails here too
    a_result_value: assert property (@(posedge clk) disable iff (rst)
        out_vld && out_rdy && exp_valid |-> out_data.fm == exp_fm)
        else begin
            errors++;
            $display("Mismatch out_data.fm: expected %h actual %h", exp_fm, out_data.fm);
        end

    a_out_held: assert property (@(posedge clk) disable iff (rst)
        stall_chk |-> out_vld && out_data == held_chk)
        else begin
            errors++;
            $display("Mismatch out_data under stall: expected %h actual %h", held_chk, out_data);
        end

    a_addr_supplied: assert property (@(posedge clk) disable iff (rst)
        mem_addr_vld && mem_addr_rdy |-> addr_known)
        else begin
            errors++;
            $display("Read of address %h with no matching supplied index", mem_addr);
        end

    // Every reply belongs to a running core, so it is always taken
    a_fm_taken: assert property (@(posedge clk) disable iff (rst)
        mem_fm_vld |-> mem_fm_rdy)
        else begin
            errors++;
            $display("Feature reply refused while its read was outstanding");
        end

    // ========================================
    // Stimulus
    // ========================================
    always @(posedge clk) begin
        #1;
        out_rdy = ($urandom % 4) != 0;
    end

    task automatic send_cfg(input int k);
        bit done;
        cfg_k   = pool_pkg::kcnt_t'(k);
        cfg_vld = 1'b1;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = cfg_rdy;
            @(posedge clk);
            #1;
        end
        cfg_vld = 1'b0;
    endtask

    task automatic present_beat();
        for (int c = 0; c < POOL_CORE; c++) begin
            idx_word[c] = pool_pkg::idx_t'($urandom);
        end
        idx_vld = 1'b1;
    endtask

    task automatic finish_beat();
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = idx_rdy;
            @(posedge clk);
            #1;
        end
        idx_vld = 1'b0;
    endtask

    task automatic send_beat();
        present_beat();
        finish_beat();
    endtask

    task automatic check_drained();
        int left;
        left = 0;
        for (int a = 0; a < ADDR_SPAN; a++) begin
            left += pending[a];
        end
        assert (left == 0) else begin
            errors++;
            $display("Run ended with %0d supplied indices never read", left);
        end
    endtask

    initial begin
        void'($urandom(32'h6f46_0a2d));
        clk      = 1'b0;
        rst      = 1'b1;
        cfg_vld  = 1'b0;
        cfg_k    = '0;
        idx_vld  = 1'b0;
        idx_word = '0;
        out_rdy  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // First beat waits on the unconfigured cores
        present_beat();
        repeat (6) @(posedge clk);
        #1;
        send_cfg(K1);
        finish_beat();
        repeat (G1 * K1 - 1) send_beat();
        // Each new K goes in while the previous groups still drain
        send_cfg(K2);
        repeat (G2 * K2) send_beat();
        send_cfg(K3);
        repeat (G3 * K3) send_beat();
        while (!queues_empty()) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        check_drained();
        $display("Results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units, results still outstanding", WATCHDOG_TIME);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/feature_mem_model.sv ====
// Feature memory model for the pool_unit testbench
// Random address stall, random latency of 1 to 5 cycles, replies in order
// Handshakes sampled on the falling edge, outputs driven 1 unit after rise
`default_nettype none

module feature_mem_model (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           addr_vld,
    input  wire pool_pkg::idx_t addr,
    output logic                addr_rdy,
    output logic                fm_vld,
    output pool_pkg::fm_t       fm,
    input  wire logic           fm_rdy
);

    // Accepted reads and the cycle each reply becomes due
    pool_pkg::idx_t addr_q [$];
    int             due_q [$];
    int             cycle;
    int             last_due;
    logic           addr_take;
    logic           fm_take;
    pool_pkg::idx_t addr_seen;

    // Stored content, every address bit matters
    function automatic pool_pkg::fm_t make_feature(input pool_pkg::idx_t a);
        pool_pkg::fm_t f;
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
            f[ch] = pool_pkg::act_t'(int'(a) * (2 * ch + 1) + (int'(a) >> 5) * 13 + ch * 41);
        end
        return f;
    endfunction

    initial begin
        addr_rdy  = 1'b0;
        fm_vld    = 1'b0;
        fm        = '0;
        cycle     = 0;
        last_due  = 0;
        addr_take = 1'b0;
        fm_take   = 1'b0;
    end

    // Transfers that complete on the coming edge
    always @(negedge clk) begin
        addr_take = addr_vld && addr_rdy;
        addr_seen = addr;
        fm_take   = fm_vld && fm_rdy;
    end

    always @(posedge clk) begin : mem_step
        int lat;
        cycle++;
        if (rst) begin
            addr_q.delete();
            due_q.delete();
        end else begin
            if (fm_take) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (addr_take) begin
                lat      = 1 + int'($urandom % 5);
                // In order, never earlier than the reply ahead of it
                last_due = (cycle + lat > last_due) ? cycle + lat : last_due;
                addr_q.push_back(addr_seen);
                due_q.push_back(last_due);
            end
        end
        #1;
        addr_rdy = !rst && (($urandom % 8) != 0);
        fm_vld   = (due_q.size() > 0) && (due_q[0] <= cycle);
        fm       = fm_vld ? make_feature(addr_q[0]) : '0;
    end

endmodule

`default_nettype wire

// ==== src/pool_unit.sv ====
// Max-pooling unit top: POOL_CORE cores sharing one feature memory port
// idx_word carries one index per core, core 0 in the lowest bits
// All cores take their index in the same beat
// Reconfigure only when cfg_rdy is high, K must be at least 1
`default_nettype none

module pool_unit #(
    parameter int POOL_CORE = 4,
    parameter int TAG_DEPTH = 8
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            cfg_vld,
    input  wire pool_pkg::kcnt_t                 cfg_k,
    output logic                                 cfg_rdy,
    input  wire logic                            idx_vld,
    input  wire pool_pkg::idx_t [POOL_CORE-1:0]  idx_word,
    output logic                                 idx_rdy,
    output logic                                 mem_addr_vld,
    output pool_pkg::idx_t                       mem_addr,
    input  wire logic                            mem_addr_rdy,
    input  wire logic                            mem_fm_vld,
    input  wire pool_pkg::fm_t                   mem_fm,
    output logic                                 mem_fm_rdy,
    output logic                                 out_vld,
    output pool_pkg::pool_out_t                  out_data,
    input  wire logic                            out_rdy
);

    // ========================================
    // Core side wiring
    // ========================================
    logic [POOL_CORE-1:0]                core_idx_rdy;
    logic [POOL_CORE-1:0]                core_addr_vld;
    logic [POOL_CORE-1:0]                core_addr_rdy;
    pool_pkg::idx_t [POOL_CORE-1:0]      core_addr;
    logic [POOL_CORE-1:0]                core_fm_vld;
    logic [POOL_CORE-1:0]                core_fm_rdy;
    pool_pkg::fm_t                       core_fm;
    logic [POOL_CORE-1:0]                core_res_vld;
    logic [POOL_CORE-1:0]                core_res_rdy;
    pool_pkg::pool_out_t [POOL_CORE-1:0] core_res;
    logic [POOL_CORE-1:0]                core_idle;
    logic                                cfg_load;
    logic                                idx_take;

    assign cfg_rdy  = &core_idle;
    assign cfg_load = cfg_vld && cfg_rdy;
    // Index beat only when every core can take its slice
    assign idx_rdy  = &core_idx_rdy;
    assign idx_take = idx_vld && idx_rdy;

    for (genvar i = 0; i < POOL_CORE; i++) begin : g_core
        pool_core pool_core_inst (
            .clk      (clk),
            .rst      (rst),
            .cfg_load (cfg_load),
            .cfg_k    (cfg_k),
            .idx_vld  (idx_take),
            .idx      (idx_word[i]),
            .idx_rdy  (core_idx_rdy[i]),
            .addr_vld (core_addr_vld[i]),
            .addr     (core_addr[i]),
            .addr_rdy (core_addr_rdy[i]),
            .fm_vld   (core_fm_vld[i]),
            .fm       (core_fm),
            .fm_rdy   (core_fm_rdy[i]),
            .res_vld  (core_res_vld[i]),
            .res      (core_res[i]),
            .res_rdy  (core_res_rdy[i]),
            .core_id  (pool_pkg::core_id_t'(i)),
            .idle     (core_idle[i])
        );
    end

    pool_mem_if #(
        .POOL_CORE (POOL_CORE),
        .TAG_DEPTH (TAG_DEPTH)
    ) pool_mem_if_inst (
        .clk           (clk),
        .rst           (rst),
        .core_addr_vld (core_addr_vld),
        .core_addr     (core_addr),
        .core_addr_rdy (core_addr_rdy),
        .core_fm_vld   (core_fm_vld),
        .core_fm       (core_fm),
        .core_fm_rdy   (core_fm_rdy),
        .mem_addr_vld  (mem_addr_vld),
        .mem_addr      (mem_addr),
        .mem_addr_rdy  (mem_addr_rdy),
        .mem_fm_vld    (mem_fm_vld),
        .mem_fm        (mem_fm),
        .mem_fm_rdy    (mem_fm_rdy)
    );

    // ========================================
    // Output select
    // ========================================
    pool_pkg::core_id_t pick;
    pool_pkg::core_id_t sel_id;
    pool_pkg::core_id_t sel_id_q;
    logic               pick_any;
    logic               sel_hold_q;

    // Lowest-numbered valid core wins
    always_comb begin
        pick     = '0;
        pick_any = 1'b0;
        for (int c = POOL_CORE - 1; c >= 0; c--) begin
            if (core_res_vld[c]) begin
                pick     = pool_pkg::core_id_t'(c);
                pick_any = 1'b1;
            end
        end
    end

    // Keep a stalled result on the port even if a lower core fills up
    assign sel_id   = sel_hold_q ? sel_id_q : pick;
    assign out_vld  = sel_hold_q || pick_any;
    assign out_data = core_res[sel_id];

    always_comb begin
        core_res_rdy         = '0;
        core_res_rdy[sel_id] = out_rdy && out_vld;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_hold_q <= 1'b0;
        end else begin
            sel_hold_q <= out_vld && !out_rdy;
        end
    end

    always_ff @(posedge clk) begin
        sel_id_q <= sel_id;
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_vld && !out_rdy |=> out_vld && $stable(out_data));

endmodule

`default_nettype wire

// ==== src/pool_mem_if.sv ====
// Read arbiter between the pooling cores and one feature memory port
// Memory must return data in the order addresses were accepted
// At most TAG_DEPTH reads in flight, further addresses wait
// Grant is held while the memory stalls an offered address
`default_nettype none

module pool_mem_if #(
    parameter int POOL_CORE = 4,
    parameter int TAG_DEPTH = 8
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [POOL_CORE-1:0]            core_addr_vld,
    input  wire pool_pkg::idx_t [POOL_CORE-1:0]  core_addr,
    output logic [POOL_CORE-1:0]                 core_addr_rdy,
    output logic [POOL_CORE-1:0]                 core_fm_vld,
    output pool_pkg::fm_t                        core_fm,
    input  wire logic [POOL_CORE-1:0]            core_fm_rdy,
    output logic                                 mem_addr_vld,
    output pool_pkg::idx_t                       mem_addr,
    input  wire logic                            mem_addr_rdy,
    input  wire logic                            mem_fm_vld,
    input  wire pool_pkg::fm_t                   mem_fm,
    output logic                                 mem_fm_rdy
);

    localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CNT_W = $clog2(TAG_DEPTH + 1);

    // ========================================
    // Round-robin arbiter
    // ========================================
    pool_pkg::core_id_t rr_ptr_q;
    pool_pkg::core_id_t rr_id;
    pool_pkg::core_id_t gnt_id;
    pool_pkg::core_id_t hold_id_q;
    logic               hold_q;
    logic               rr_any;
    logic               req;
    pool_pkg::core_id_t cand;

    // Scan from rr_ptr_q, nearest requester wins
    always_comb begin
        rr_id  = rr_ptr_q;
        rr_any = 1'b0;
        cand   = '0;
        for (int off = POOL_CORE - 1; off >= 0; off--) begin
            cand = pool_pkg::core_id_t'((int'(rr_ptr_q) + off) % POOL_CORE);
            if (core_addr_vld[cand]) begin
                rr_id  = cand;
                rr_any = 1'b1;
            end
        end
    end

    assign gnt_id = hold_q ? hold_id_q : rr_id;
    assign req    = hold_q || rr_any;

    // ========================================
    // Tag FIFO
    // ========================================
    pool_pkg::core_id_t tag_mem [TAG_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;
    pool_pkg::core_id_t head;

    assign full  = (count_q == CNT_W'(TAG_DEPTH));
    assign empty = (count_q == '0);
    assign head  = tag_mem[rd_ptr_q];

    // Address path, no register
    assign mem_addr_vld = req && !full;
    assign mem_addr     = core_addr[gnt_id];
    assign push         = mem_addr_vld && mem_addr_rdy;

    always_comb begin
        core_addr_rdy         = '0;
        core_addr_rdy[gnt_id] = mem_addr_rdy && !full && req;
    end

    // Feature routing from the FIFO head
    assign core_fm    = mem_fm;
    assign mem_fm_rdy = !empty && core_fm_rdy[head];
    assign pop        = mem_fm_vld && mem_fm_rdy;

    always_comb begin
        core_fm_vld       = '0;
        core_fm_vld[head] = mem_fm_vld && !empty;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr_q <= '0;
            hold_q   <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            hold_q <= mem_addr_vld && !mem_addr_rdy;
            if (push) begin
                rr_ptr_q <= (int'(gnt_id) == POOL_CORE - 1) ? '0
                                                             : gnt_id + pool_pkg::core_id_t'(1);
                wr_ptr_q <= (wr_ptr_q == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        hold_id_q <= gnt_id;
        if (push) begin
            tag_mem[wr_ptr_q] <= gnt_id;
        end
    end

    // ========================================
    // Assertions
    // ========================================
    // Count and pointers agree at both ends, no overflow past full
    a_ptr_count: assert property (@(posedge clk) disable iff (rst)
        full || empty |-> wr_ptr_q == rd_ptr_q);

    // Memory returns only data that was asked for
    a_no_fm_empty: assert property (@(posedge clk) disable iff (rst)
        mem_fm_vld |-> !empty);

endmodule

`default_nettype wire

// ==== src/pool_core.sv ====
// One pooling core: turns K indices into reads, max-reduces the K replies
// Expects replies only for its own reads, in issue order
// cfg_load is only legal while idle is high
// The result is held in HOLD until it transfers, then the next group starts
`default_nettype none

module pool_core (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cfg_load,
    input  wire pool_pkg::kcnt_t      cfg_k,
    input  wire logic                 idx_vld,
    input  wire pool_pkg::idx_t       idx,
    output logic                      idx_rdy,
    output logic                      addr_vld,
    output pool_pkg::idx_t            addr,
    input  wire logic                 addr_rdy,
    input  wire logic                 fm_vld,
    input  wire pool_pkg::fm_t        fm,
    output logic                      fm_rdy,
    output logic                      res_vld,
    output pool_pkg::pool_out_t       res,
    input  wire logic                 res_rdy,
    input  wire pool_pkg::core_id_t   core_id,
    output logic                      idle
);

    // ========================================
    // State and counters
    // ========================================
    pool_pkg::core_state_e state_q;
    pool_pkg::kcnt_t       k_q;
    // Indices taken / features returned in this group
    pool_pkg::kcnt_t       issue_cnt_q;
    pool_pkg::kcnt_t       ret_cnt_q;
    pool_pkg::kcnt_t       ret_nxt;
    pool_pkg::idx_t        addr_q;
    logic                  addr_vld_q;
    pool_pkg::fm_t         max_q;
    pool_pkg::fm_t         max_nxt;
    logic                  idx_xfer;
    logic                  addr_xfer;
    logic                  fm_xfer;
    logic                  res_xfer;

    // One outstanding address at a time, K per group
    assign idx_rdy = (state_q == pool_pkg::RUN) && !addr_vld_q &&
                     (issue_cnt_q != k_q) && !cfg_load;
    assign addr_vld = addr_vld_q;
    assign addr     = addr_q;
    assign fm_rdy   = (state_q == pool_pkg::RUN);
    assign res_vld  = (state_q == pool_pkg::HOLD);
    assign res      = {core_id, max_q};

    // Nothing in flight, safe to reconfigure
    assign idle = (state_q == pool_pkg::IDLE) ||
                  ((state_q == pool_pkg::RUN) && (issue_cnt_q == '0));

    assign idx_xfer  = idx_vld && idx_rdy;
    assign addr_xfer = addr_vld_q && addr_rdy;
    assign fm_xfer   = fm_vld && fm_rdy;
    assign res_xfer  = res_vld && res_rdy;
    assign ret_nxt   = ret_cnt_q + pool_pkg::kcnt_t'(1);

    // ========================================
    // Channel-wise unsigned maximum
    // ========================================
    always_comb begin
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
            max_nxt[ch] = (fm[ch] > max_q[ch]) ? fm[ch] : max_q[ch];
        end
    end

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= pool_pkg::IDLE;
            k_q         <= '0;
            issue_cnt_q <= '0;
            ret_cnt_q   <= '0;
            addr_vld_q  <= 1'b0;
        end else if (cfg_load) begin
            // New K, group starts empty
            k_q         <= cfg_k;
            state_q     <= pool_pkg::RUN;
            issue_cnt_q <= '0;
            ret_cnt_q   <= '0;
        end else begin
            case (state_q)
                pool_pkg::RUN: begin
                    if (idx_xfer) begin
                        addr_vld_q  <= 1'b1;
                        issue_cnt_q <= issue_cnt_q + pool_pkg::kcnt_t'(1);
                    end else if (addr_xfer) begin
                        addr_vld_q <= 1'b0;
                    end
                    if (fm_xfer) begin
                        ret_cnt_q <= ret_nxt;
                        // Last of K replies closes the group
                        if (ret_nxt == k_q) begin
                            state_q <= pool_pkg::HOLD;
                        end
                    end
                end
                pool_pkg::HOLD: begin
                    if (res_xfer) begin
                        state_q     <= pool_pkg::RUN;
                        issue_cnt_q <= '0;
                        ret_cnt_q   <= '0;
                    end
                end
                default: begin
                    state_q <= pool_pkg::IDLE;
                end
            endcase
        end
    end

    // Pending address and running maximum
    always_ff @(posedge clk) begin
        if (idx_xfer) begin
            addr_q <= idx;
        end
        if (cfg_load || res_xfer) begin
            max_q <= '0;
        end else if (fm_xfer) begin
            max_q <= max_nxt;
        end
    end

    // ========================================
    // Assertions
    // ========================================
    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        res_vld && !res_rdy |=> $stable(res));

    // Memory interface must never route data to an unconfigured core
    a_no_fm_idle: assert property (@(posedge clk) disable iff (rst)
        !(fm_vld && (state_q == pool_pkg::IDLE)));

endmodule

`default_nettype wire

// ==== src/pool_pkg.sv ====
// Widths, vector types and result struct for the max-pooling unit
// Activations are unsigned, the maximum is taken per channel
// K up to 2**KCNT_WIDTH-1, POOL_CORE at most 2**CORE_ID_WIDTH
`default_nettype none

package pool_pkg;

    // ========================================
    // Widths
    // ========================================
    // Neighbour index doubles as feature address
    localparam int IDX_WIDTH     = 10;
    localparam int ACT_WIDTH     = 8;
    // Activations per feature word
    localparam int CHANNELS      = 8;
    localparam int KCNT_WIDTH    = 5;
    localparam int CORE_ID_WIDTH = 2;

    // ========================================
    // Vector types
    // ========================================
    typedef logic [IDX_WIDTH-1:0]     idx_t;
    typedef logic [ACT_WIDTH-1:0]     act_t;
    typedef logic [KCNT_WIDTH-1:0]    kcnt_t;
    typedef logic [CORE_ID_WIDTH-1:0] core_id_t;

    // Channel 0 in the lowest bits
    typedef act_t [CHANNELS-1:0] fm_t;

    // Pooled vector tagged with its producer
    typedef struct packed {
        core_id_t core;
        fm_t      fm;
    } pool_out_t;

    // Core FSM
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } core_state_e;

endpackage

`default_nettype wire
